/* out_sched_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// word layout shared by queues, selector and crc unit
////////////////////////////////////////////////////////////////////////////

package out_sched_pkg;

    localparam int word_width = 48;                 // queue and output word
    localparam int pri_width  = 2;                  // four priority levels
    localparam int len_width  = 8;                  // data words per frame
    localparam int crc_width  = 32;
    localparam int rsv_width  = word_width - len_width - crc_width - pri_width;

    // crc-32, msb first, init all ones, no reflection, no final xor
    localparam logic [crc_width-1:0] crc_poly = 32'h04C1_1DB7;

    // header view of the first word of a frame
    typedef struct packed {
        logic [rsv_width-1:0] rsvd;
        logic [len_width-1:0] len;                  // 1 to 255
        logic [crc_width-1:0] crc;                  // expected crc over data words
        logic [pri_width-1:0] pri;
    } frame_hdr_t;

    // one queue word, header or payload
    typedef union packed {
        frame_hdr_t              hdr;
        logic [word_width-1:0]   raw;
    } frame_word_u;

endpackage

`default_nettype wire

/* frame_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_queue import out_sched_pkg::*; #(
    parameter int depth = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [word_width-1:0] wr_data,
    input  logic                  rd_en,
    output logic [word_width-1:0] rd_data,
    output logic                  empty,
    output logic                  full
);

    localparam int addr_w = $clog2(depth);

    logic [word_width-1:0] mem [depth];
    logic [addr_w-1:0]     wr_ptr;
    logic [addr_w-1:0]     rd_ptr;
    logic [addr_w:0]       count;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = wr_en && !full;      // writes into a full queue are dropped
    assign do_rd = rd_en && !empty;
    assign empty = (count == '0);
    assign full  = (count == (addr_w+1)'(depth));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr];     // word shows up the cycle after rd_en
    end

endmodule

`default_nettype wire

/* pri_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module pri_arbiter import out_sched_pkg::*; #(
    parameter int port_num = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          arb_en,
    input  logic [port_num-1:0]           request,
    input  logic [port_num*pri_width-1:0] priorities,
    input  logic                          scheme,     // 0 fixed, 1 rotate ties
    output logic [$clog2(port_num)-1:0]   grant,
    output logic                          grant_vld
);

    localparam int sel_w = $clog2(port_num);

    logic [pri_width-1:0] top_pri;
    logic [port_num-1:0]  tied;
    logic [sel_w-1:0]     pick_fix;
    logic [sel_w-1:0]     pick_rot;
    logic [sel_w-1:0]     last_grant;     // rotation pointer
    int                   idx;

    ////////////////////////////////////////////////////////////////////////
    // highest priority among requesters
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        top_pri = '0;
        for (int i = 0; i < port_num; i++) begin
            if (request[i] && priorities[i*pri_width +: pri_width] > top_pri)
                top_pri = priorities[i*pri_width +: pri_width];
        end
        for (int i = 0; i < port_num; i++)
            tied[i] = request[i] && (priorities[i*pri_width +: pri_width] == top_pri);
    end

    // lowest tied index
    always_comb begin
        pick_fix = '0;
        for (int i = port_num - 1; i >= 0; i--) begin
            if (tied[i])
                pick_fix = sel_w'(i);
        end
    end

    // first tied port after the last grant, last grant itself comes last
    always_comb begin
        pick_rot = last_grant;
        idx      = 0;
        for (int k = port_num; k >= 1; k--) begin
            idx = (int'(last_grant) + k) % port_num;
            if (tied[idx])
                pick_rot = sel_w'(idx);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant      <= '0;
            grant_vld  <= 1'b0;
            last_grant <= sel_w'(port_num - 1);     // port 0 first after reset
        end else begin
            grant_vld <= arb_en && (request != '0);
            if (arb_en && request != '0) begin
                grant      <= scheme ? pick_rot : pick_fix;
                last_grant <= scheme ? pick_rot : pick_fix;
            end
        end
    end

endmodule

`default_nettype wire

/* crc32_acc.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32_acc import out_sched_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  crc_clr,
    input  logic                  crc_en,
    input  logic [word_width-1:0] data,
    output logic [crc_width-1:0]  crc_out
);

    logic [crc_width-1:0] crc_next;
    logic                 fb;

    // all 48 bit steps in one cycle, msb of the word first
    always_comb begin
        crc_next = crc_out;
        fb       = 1'b0;
        for (int i = word_width - 1; i >= 0; i--) begin
            fb       = crc_next[crc_width-1] ^ data[i];
            crc_next = {crc_next[crc_width-2:0], 1'b0};
            if (fb)
                crc_next = crc_next ^ crc_poly;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            crc_out <= '1;
        else if (crc_clr)
            crc_out <= '1;          // clear wins over a fold
        else if (crc_en)
            crc_out <= crc_next;
    end

endmodule

`default_nettype wire

/* sel_control.sv */
`timescale 1ns/1ps
`default_nettype none

module sel_control import out_sched_pkg::*; #(
    parameter int port_num = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [word_width-1:0]         q_data,
    input  logic [port_num-1:0]           empty,
    input  logic                          ready,
    input  logic                          scheme,
    input  logic [$clog2(port_num)-1:0]   grant,
    input  logic                          grant_vld,
    input  logic [crc_width-1:0]          crc_out,
    output logic                          rd_en,
    output logic [$clog2(port_num)-1:0]   rd_sel,
    output logic                          arb_en,
    output logic [port_num-1:0]           request,
    output logic [port_num*pri_width-1:0] priorities,
    output logic                          crc_clr,
    output logic                          crc_en,
    output logic [word_width-1:0]         rd_data,
    output logic                          rd_vld,
    output logic                          rd_sop,
    output logic                          rd_eop,
    output logic [$clog2(port_num)-1:0]   rd_port,
    output logic                          error
);

    localparam int sel_w = $clog2(port_num);

    localparam logic [1:0] st_scan     = 2'd0;
    localparam logic [1:0] st_hdr_wait = 2'd1;
    localparam logic [1:0] st_send     = 2'd2;

    logic [1:0]           state;
    logic [sel_w-1:0]     scan_ptr;
    logic [sel_w-1:0]     cur_port;
    logic                 granted;
    logic [len_width-1:0] left;             // data reads still to issue
    logic                 first_rd;
    logic                 last_rd;
    logic                 chk;              // crc holds the whole frame
    logic [port_num-1:0]  need_hdr;
    logic                 hdr_cap;
    frame_word_u          q_word;

    // per-port frame table
    logic [port_num-1:0]  tbl_vld;
    logic [pri_width-1:0] tbl_pri [port_num];
    logic [crc_width-1:0] tbl_crc [port_num];
    logic [len_width-1:0] tbl_len [port_num];

    function automatic logic [sel_w-1:0] wrap_inc(input logic [sel_w-1:0] p);
        return (p == sel_w'(port_num - 1)) ? '0 : p + 1'b1;
    endfunction

    assign q_word   = q_data;
    assign rd_data  = q_word.raw;           // payload view after the header
    assign need_hdr = ~empty & ~tbl_vld;
    assign hdr_cap  = (state == st_hdr_wait) && !rd_en;
    assign request  = tbl_vld;
    assign crc_en   = rd_vld;
    assign rd_port  = cur_port;

    always_comb begin
        for (int i = 0; i < port_num; i++)
            priorities[i*pri_width +: pri_width] = tbl_pri[i];
    end

    ////////////////////////////////////////////////////////////////////////
    // header capture into the table
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (hdr_cap) begin
            tbl_pri[rd_sel] <= q_word.hdr.pri;
            tbl_crc[rd_sel] <= q_word.hdr.crc;
            tbl_len[rd_sel] <= q_word.hdr.len;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // scan, arbitration and streaming
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_scan;
            scan_ptr <= '0;
            cur_port <= '0;
            granted  <= 1'b0;
            left     <= '0;
            first_rd <= 1'b0;
            last_rd  <= 1'b0;
            chk      <= 1'b0;
            tbl_vld  <= '0;
            rd_en    <= 1'b0;
            rd_sel   <= '0;
            arb_en   <= 1'b0;
            crc_clr  <= 1'b0;
            rd_vld   <= 1'b0;
            rd_sop   <= 1'b0;
            rd_eop   <= 1'b0;
            error    <= 1'b0;
        end else begin
            rd_en   <= 1'b0;                // one-cycle strobes
            arb_en  <= 1'b0;
            crc_clr <= 1'b0;
            rd_vld  <= rd_en && (state == st_send);
            rd_sop  <= rd_en && (state == st_send) && first_rd;
            rd_eop  <= rd_en && (state == st_send) && last_rd;
            chk     <= rd_eop;
            case (state)
                st_scan: begin
                    if (need_hdr[scan_ptr]) begin
                        rd_en  <= 1'b1;     // header read
                        rd_sel <= scan_ptr;
                        state  <= st_hdr_wait;
                    end else begin
                        scan_ptr <= wrap_inc(scan_ptr);
                        if (need_hdr == '0 && tbl_vld != '0 && ready) begin
                            arb_en  <= 1'b1;
                            crc_clr <= 1'b1;
                            granted <= 1'b0;
                            state   <= st_send;
                        end
                    end
                end
                st_hdr_wait: begin
                    if (!rd_en) begin       // header is on q_data now
                        tbl_vld[rd_sel] <= 1'b1;
                        scan_ptr        <= wrap_inc(scan_ptr);
                        state           <= st_scan;
                    end
                end
                st_send: begin
                    if (!granted) begin
                        if (grant_vld) begin
                            granted  <= 1'b1;
                            cur_port <= grant;
                            rd_sel   <= grant;
                            first_rd <= 1'b1;
                            if (ready && !empty[grant]) begin
                                rd_en   <= 1'b1;
                                last_rd <= (tbl_len[grant] == len_width'(1));
                                left    <= tbl_len[grant] - 1'b1;
                            end else begin
                                left <= tbl_len[grant];
                            end
                        end
                    end else if (left != '0) begin
                        if (ready && !empty[cur_port]) begin
                            rd_en    <= 1'b1;
                            first_rd <= (left == tbl_len[cur_port]);
                            last_rd  <= (left == len_width'(1));
                            left     <= left - 1'b1;
                        end
                    end else if (chk) begin
                        if (crc_out != tbl_crc[cur_port])
                            error <= 1'b1;  // sticky until reset
                        tbl_vld[cur_port] <= 1'b0;
                        granted           <= 1'b0;
                        scan_ptr          <= scheme ? wrap_inc(cur_port) : '0;
                        state             <= st_scan;
                    end
                end
                default: state <= st_scan;
            endcase
        end
    end

endmodule

`default_nettype wire

/* out_sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module out_sched_top import out_sched_pkg::*; #(
    parameter int port_num    = 4,
    parameter int queue_depth = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [port_num-1:0]         wr_en,
    input  logic [word_width-1:0]       wr_data,
    input  logic                        ready,
    input  logic                        scheme,
    output logic [port_num-1:0]         full,
    output logic [word_width-1:0]       rd_data,
    output logic                        rd_vld,
    output logic                        rd_sop,
    output logic                        rd_eop,
    output logic [$clog2(port_num)-1:0] rd_port,
    output logic                        error
);

    localparam int sel_w = $clog2(port_num);

    logic [word_width-1:0]          q_rd [port_num];
    logic [word_width-1:0]          q_data;
    logic [port_num-1:0]            empty;
    logic                           rd_en;
    logic [sel_w-1:0]               rd_sel;
    logic                           arb_en;
    logic [port_num-1:0]            request;
    logic [port_num*pri_width-1:0]  priorities;
    logic [sel_w-1:0]               grant;
    logic                           grant_vld;
    logic                           crc_clr;
    logic                           crc_en;
    logic [crc_width-1:0]           crc_out;

    // one queue per input port, read strobe decoded by rd_sel
    for (genvar p = 0; p < port_num; p++) begin : g_queue
        frame_queue #(.depth(queue_depth)) u_frame_queue (
            .clk(clk), .rst_n(rst_n), .wr_en(wr_en[p]), .wr_data(wr_data),
            .rd_en(rd_en && (rd_sel == sel_w'(p))), .rd_data(q_rd[p]),
            .empty(empty[p]), .full(full[p])
        );
    end

    assign q_data = q_rd[rd_sel];           // shared read mux

    sel_control #(.port_num(port_num)) u_sel_control (
        .clk(clk), .rst_n(rst_n), .q_data(q_data), .empty(empty), .ready(ready),
        .scheme(scheme), .grant(grant), .grant_vld(grant_vld), .crc_out(crc_out),
        .rd_en(rd_en), .rd_sel(rd_sel), .arb_en(arb_en), .request(request),
        .priorities(priorities), .crc_clr(crc_clr), .crc_en(crc_en),
        .rd_data(rd_data), .rd_vld(rd_vld), .rd_sop(rd_sop), .rd_eop(rd_eop),
        .rd_port(rd_port), .error(error)
    );

    pri_arbiter #(.port_num(port_num)) u_pri_arbiter (
        .clk(clk), .rst_n(rst_n), .arb_en(arb_en), .request(request),
        .priorities(priorities), .scheme(scheme), .grant(grant), .grant_vld(grant_vld)
    );

    crc32_acc u_crc32_acc (
        .clk(clk), .rst_n(rst_n), .crc_clr(crc_clr), .crc_en(crc_en),
        .data(rd_data), .crc_out(crc_out)
    );

endmodule

`default_nettype wire

/* out_sched_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module out_sched_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic ready,
    input  logic rd_en,
    input  logic arb_en,
    input  logic rd_vld,
    input  logic rd_sop,
    input  logic rd_eop,
    input  logic error
);

    int   fail_cnt = 0;
    logic in_frame;                     // between sop and eop

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            in_frame <= 1'b0;
        else if (rd_vld && rd_eop)
            in_frame <= 1'b0;
        else if (rd_vld && rd_sop)
            in_frame <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // framing marks
    ////////////////////////////////////////////////////////////////////////////
    a_marks_vld: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_sop || rd_eop) |-> rd_vld) else begin
        fail_cnt++;
        $error("rd_sop or rd_eop high without rd_vld");
    end

    a_sop_order: assert property (@(posedge clk) disable iff (!rst_n)
        rd_sop |-> !in_frame) else begin
        fail_cnt++;
        $error("new rd_sop before the previous frame ended");
    end

    a_body_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld && !rd_sop) |-> in_frame) else begin
        fail_cnt++;
        $error("valid word outside a frame");
    end

    // sticky error and back-pressure
    a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        error |=> error) else begin
        fail_cnt++;
        $error("error flag fell without a reset");
    end

    a_ready_slip: assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld |-> $past(ready, 2)) else begin
        fail_cnt++;
        $error("more than one word presented after ready dropped");
    end

    a_quiet: assert property (@(posedge clk)
        $rose(rst_n) |=> !(rd_en || arb_en || rd_vld || rd_sop || rd_eop || error))
        else begin
        fail_cnt++;
        $error("controls active right after reset");
    end

endmodule

bind out_sched_top out_sched_checker u_out_sched_checker (
    .clk(clk), .rst_n(rst_n), .ready(ready), .rd_en(rd_en), .arb_en(arb_en),
    .rd_vld(rd_vld), .rd_sop(rd_sop), .rd_eop(rd_eop), .error(error)
);

`default_nettype wire

/* tb_out_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_out_sched import out_sched_pkg::*; ();

    localparam int port_num    = 4;
    localparam int queue_depth = 16;
    localparam int max_frames  = 61;                    // all phases together
    localparam int wd_cycles   = max_frames * 7 * 20 + 16;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [port_num-1:0]   wr_en;
    logic [word_width-1:0] wr_data;
    logic                  ready = 1'b0;
    logic                  scheme;
    logic [port_num-1:0]   full;
    logic [word_width-1:0] rd_data;
    logic                  rd_vld;
    logic                  rd_sop;
    logic                  rd_eop;
    logic [1:0]            rd_port;
    logic                  error;

    logic                  ready_level  = 1'b0;
    logic                  toggle_ready = 1'b0;
    logic [word_width+1:0] exp_q [port_num][$];         // {sop, eop, word}
    logic [1:0]            order_q [$];                 // expected port per frame
    logic [word_width+1:0] exp_w;
    logic [1:0]            exp_p;
    int                    mon_errs  = 0;
    int                    flow_errs = 0;

    out_sched_top #(.port_num(port_num), .queue_depth(queue_depth)) u_out_sched_top (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_data(wr_data), .ready(ready),
        .scheme(scheme), .full(full), .rd_data(rd_data), .rd_vld(rd_vld), .rd_sop(rd_sop),
        .rd_eop(rd_eop), .rd_port(rd_port), .error(error)
    );

    always #2 clk = ~clk;                               // 4 ns period

    always @(negedge clk) begin
        if (toggle_ready)
            ready = ($urandom() % 4) != 0;              // high about three cycles in four
        else
            ready = ready_level;
    end

    // crc-32 reference, msb first, no reflection
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [word_width-1:0] d);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int i = word_width - 1; i >= 0; i--) begin
            fb = r[31] ^ d[i];
            r  = {r[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
        end
        return r;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < port_num; p++)
            n += exp_q[p].size();
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    // never more than two frames per queue, so a write always finds room
    task automatic check_room(input logic [1:0] port);
        assert (full[port] == 1'b0) else begin
            flow_errs++;
            $display("Mismatch full[%0d]: got %h expected %h", port, full[port], 1'b0);
        end
    endtask

    task automatic send_frame(input logic [1:0] port, input logic [1:0] pri, input logic corrupt);
        logic [word_width-1:0] data [$];
        logic [7:0]            len;
        logic [31:0]           crc;
        len = 8'($urandom_range(6, 1));
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < int'(len); i++) begin
            data.push_back({16'($urandom()), $urandom()});
            crc = crc_step(crc, data[i]);
            exp_q[port].push_back({i == 0, i == int'(len) - 1, data[i]});
        end
        if (corrupt)
            crc = crc ^ 32'h0000_0100;                  // one flipped bit
        @(negedge clk);
        check_room(port);
        wr_en   = 4'b0001 << port;
        wr_data = {6'd0, len, crc, pri};
        for (int i = 0; i < int'(len); i++) begin
            @(negedge clk);
            check_room(port);
            wr_data = data[i];
        end
        @(negedge clk);
        wr_en = '0;
    endtask

    task automatic drain(input logic err_exp);
        repeat (30) @(negedge clk);                     // headers land in the table
        ready_level = 1'b1;
        while (pending() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        assert (error == err_exp) else begin
            flow_errs++;
            $display("Mismatch error: got %h expected %h", error, err_exp);
        end
        assert (order_q.size() == 0) else begin
            flow_errs++;
            $display("fewer frames left the output than were expected in order");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n && rd_vld) begin
            if (exp_q[rd_port].size() == 0) begin
                mon_errs++;
                $display("word on port %0d with no frame pending there", rd_port);
            end else begin
                exp_w = exp_q[rd_port].pop_front();
                assert (rd_data == exp_w[word_width-1:0]) else begin
                    mon_errs++;
                    $display("Mismatch rd_data: got %h expected %h", rd_data,
                             exp_w[word_width-1:0]);
                end
                assert ({rd_sop, rd_eop} == exp_w[word_width+1:word_width]) else begin
                    mon_errs++;
                    $display("Mismatch rd_sop/rd_eop: got %h expected %h", {rd_sop, rd_eop},
                             exp_w[word_width+1:word_width]);
                end
            end
            if (rd_sop) begin
                if (order_q.size() != 0) begin
                    exp_p = order_q.pop_front();
                    assert (rd_port == exp_p) else begin
                        mon_errs++;
                        $display("Mismatch rd_port: got %h expected %h", rd_port, exp_p);
                    end
                end
            end
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: frames did not drain within %0d cycles", wd_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic [1:0] pri_of [port_num];
        logic [1:0] base;
        logic [1:0] prev_port;
        int         chk_errs;
        void'($urandom(6352));
        pri_of   = '{2'd1, 2'd3, 2'd0, 2'd2};
        rst_n    = 1'b1;
        wr_en    = '0;
        wr_data  = '0;
        scheme   = 1'b0;
        #1 rst_n = 1'b0;                                // falling edge starts the reset
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // distinct priorities, highest first
        for (int p = 0; p < port_num; p++)
            send_frame(2'(p), pri_of[p], 1'b0);
        for (int pr = 3; pr >= 0; pr--) begin
            for (int p = 0; p < port_num; p++) begin
                if (pri_of[p] == 2'(pr))
                    order_q.push_back(2'(p));
            end
        end
        prev_port = order_q[$];                         // lowest priority is granted last
        drain(1'b0);

        // equal priorities, rotation after the last granted port
        ready_level = 1'b0;
        scheme      = 1'b1;
        @(negedge clk);
        for (int r = 0; r < 2; r++)
            for (int p = 0; p < port_num; p++)
                send_frame(2'(p), 2'd2, 1'b0);
        for (int k = 1; k <= 2 * port_num; k++)
            order_q.push_back(prev_port + 2'(k));
        drain(1'b0);

        // equal priorities, fixed mode drains port 0 first
        ready_level = 1'b0;
        scheme      = 1'b0;
        @(negedge clk);
        for (int r = 0; r < 2; r++)
            for (int p = 0; p < port_num; p++)
                send_frame(2'(p), 2'd2, 1'b0);
        for (int p = 0; p < port_num; p++) begin
            order_q.push_back(2'(p));
            order_q.push_back(2'(p));
        end
        drain(1'b0);

        // random frames under random back-pressure
        scheme       = 1'b1;
        toggle_ready = 1'b1;
        for (int r = 0; r < 10; r++) begin
            base = 2'($urandom_range(3, 0));
            for (int p = 0; p < port_num; p++)
                send_frame(base + 2'(p), 2'($urandom_range(3, 0)), 1'b0);
            drain(1'b0);
        end

        // bad header crc sets the sticky flag
        toggle_ready = 1'b0;
        send_frame(2'd2, 2'd1, 1'b1);
        drain(1'b1);

        chk_errs = u_out_sched_top.u_out_sched_checker.fail_cnt;
        $display("error count: %0d compare, %0d flow, %0d assertion",
                 mon_errs, flow_errs, chk_errs);
        if (mon_errs == 0 && flow_errs == 0 && chk_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* out_sched_top.f */
out_sched_pkg.sv
frame_queue.sv
pri_arbiter.sv
crc32_acc.sv
sel_control.sv
out_sched_top.sv
out_sched_checker.sv
tb_out_sched.sv

/* Makefile */
# Verilator build and run for the output scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_out_sched
FILELIST  ?= out_sched_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIMARGS) | tee $(LOG)
	grep -qx "Done: no errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
